/* sim.f */
common/vwrite_pkg.sv
source/store_addr_gen.sv
source/buffer_ram.sv
source/buffer_reader.sv
databus/burst_writer.sv
source/vwrite_unit.sv
verif/vwrite_tb.sv

/* Bender.yml */
package:
  name: vwrite

sources:
  - files:
      - common/vwrite_pkg.sv
      - source/store_addr_gen.sv
      - source/buffer_ram.sv
      - source/buffer_reader.sv
      - databus/burst_writer.sv
      - source/vwrite_unit.sv
  - target: test
    files:
      - verif/vwrite_tb.sv

/* verif/vwrite_tb.sv */
`timescale 1ns/100ps

module vwrite_tb import vwrite_pkg::*; ();

   logic                  clk;
   logic                  rst;
   logic                  run;
   logic                  enabled;
   logic                  pingpong;
   logic [DATA_W-1:0]     in_data;
   logic                  done;
   logic [AXI_ADDR_W-1:0] ext_addr;
   logic [ADDR_W-1:0]     amt_m1;
   logic [LEN_W-1:0]      length;
   logic [ADDR_W-1:0]     start;
   logic [ADDR_W-1:0]     incr;
   logic [ADDR_W-1:0]     shift;
   logic [ADDR_W-1:0]     iter;
   logic [PERIOD_W-1:0]   per;
   logic [PERIOD_W-1:0]   duty;
   logic [DELAY_W-1:0]    delay;
   logic                  dvalid;
   logic                  dready;
   logic [AXI_ADDR_W-1:0] daddr;
   logic [DATA_W-1:0]     dwdata;
   logic [DATA_W/8-1:0]   dwstrb;
   logic [LEN_W-1:0]      dlen;
   logic                  dlast;

   // buffer image and expected transfer state
   logic [DATA_W-1:0]     image [2**ADDR_W];
   logic                  bank;
   logic                  stall;
   logic [AXI_ADDR_W-1:0] exp_addr;
   int                    exp_remain;
   int                    exp_len;
   int                    exp_idx;
   int                    beat_cnt;
   int                    checks;
   int                    errors;
   int                    cycles;
   int                    seed;

   vwrite_unit #(
      .DATA_W  (DATA_W),
      .ADDR_W  (ADDR_W),
      .LEN_W   (LEN_W),
      .PERIOD_W(PERIOD_W)
   ) UUT (
      .clk(clk), .rst(rst), .run_i(run), .enabled_i(enabled), .pingpong_i(pingpong),
      .in_data_i(in_data), .done_o(done), .ext_addr_i(ext_addr),
      .amount_minus_one_i(amt_m1), .length_i(length), .start_i(start), .incr_i(incr),
      .shift_i(shift), .iter_i(iter), .per_i(per), .duty_i(duty), .delay_i(delay),
      .databus_valid_o(dvalid), .databus_ready_i(dready), .databus_addr_o(daddr),
      .databus_wdata_o(dwdata), .databus_wstrb_o(dwstrb), .databus_len_o(dlen),
      .databus_last_i(dlast)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // store step s of the two-level loop, with the bank bit in ping-pong mode
   function automatic void apply_store(input int s, input logic [DATA_W-1:0] w,
                                       input logic pp, input logic b);
      buf_addr_u u;
      u.addr = ADDR_W'(start + s * incr + (s / per) * shift);
      if (pp) begin
         u.pp.bank = b;
      end
      if ((s % per) < duty) begin
         image[u.addr] = w;
      end
   endfunction

   function automatic logic [ADDR_W-1:0] send_addr(input int j, input logic pp,
                                                   input logic b);
      buf_addr_u u;
      u.addr = ADDR_W'(j);
      if (pp) begin
         u.pp.bank = b;
      end
      return u.addr;
   endfunction

   function automatic int next_burst_len(input int remain);
      return (remain < int'(length)) ? remain : int'(length);
   endfunction

   task automatic program_store(input int st, input int inc, input int sh, input int it,
                                input int pe, input int du, input int dl);
      start <= ADDR_W'(st);
      incr  <= ADDR_W'(inc);
      shift <= ADDR_W'(sh);
      iter  <= ADDR_W'(it);
      per   <= PERIOD_W'(pe);
      duty  <= PERIOD_W'(du);
      delay <= DELAY_W'(dl);
   endtask

   task automatic program_transfer(input int ext, input int amount, input int len);
      ext_addr <= AXI_ADDR_W'(ext);
      amt_m1   <= ADDR_W'(amount);
      length   <= LEN_W'(len);
   endtask

   // one run: store words from the input stream, then wait for done
   task automatic run_and_wait(input logic en, input logic pp, input logic zero_fill);
      int nsteps;
      int total;
      logic [DATA_W-1:0] w;
      @(posedge clk);
      nsteps = int'(iter) * int'(per);
      total  = (nsteps == 0) ? 1 : int'(delay) + nsteps;
      run      <= 1'b1;
      enabled  <= en;
      pingpong <= pp;
      bank = pp ? !bank : 1'b0;
      if (en) begin
         exp_addr   = ext_addr;
         exp_remain = int'(amt_m1) + 1;
         exp_len    = next_burst_len(exp_remain);
         exp_idx    = 0;
         beat_cnt   = 0;
         dlast     <= (exp_len == 1);
      end
      @(posedge clk);
      run <= 1'b0;
      for (int k = 1; k <= total; k++) begin
         w = zero_fill ? '0 : DATA_W'($urandom);
         in_data <= w;
         if (nsteps > 0 && k > int'(delay)) begin
            apply_store(k - int'(delay) - 1, w, pp, bank);
         end
         @(posedge clk);
         if (k == 1) begin
            assert (done === 1'b0) else begin
               errors++;
               $display("error: done_o %h after run_i, expected 0", done);
            end
         end
      end
      while (done !== 1'b1) begin
         @(posedge clk);
      end
      if (en) begin
         assert (exp_remain == 0) else begin
            errors++;
            $display("done_o rose before every databus beat was accepted");
         end
      end
   endtask

   // databus slave and comparison of every accepted beat
   always @(posedge clk) begin
      if (!rst && dvalid && dready) begin
         logic [DATA_W-1:0] exp_w;
         exp_w = image[send_addr(exp_idx, pingpong, !bank)];
         checks++;
         assert (exp_remain > 0) else begin
            errors++;
            $display("databus beat arrived after the transfer had ended");
         end
         assert (dwdata === exp_w) else begin
            errors++;
            $display("error: databus_wdata_o %h, expected %h", dwdata, exp_w);
         end
         assert (daddr === exp_addr) else begin
            errors++;
            $display("error: databus_addr_o %h, expected %h", daddr, exp_addr);
         end
         assert (dlen === LEN_W'(exp_len)) else begin
            errors++;
            $display("error: databus_len_o %h, expected %h", dlen, LEN_W'(exp_len));
         end
         assert (dwstrb === '1 && done === 1'b0) else begin
            errors++;
            $display("error: databus_wstrb_o %h, done_o %h during a beat", dwstrb, done);
         end
         exp_idx++;
         beat_cnt++;
         if (beat_cnt == exp_len) begin
            exp_remain -= exp_len;
            exp_addr   += AXI_ADDR_W'(BYTES_PER_WORD * exp_len);
            exp_len     = next_burst_len(exp_remain);
            beat_cnt    = 0;
         end
         dlast <= (beat_cnt == exp_len - 1);
      end
   end

   always @(posedge clk) begin
      dready <= stall ? ($urandom % 3 != 0) : 1'b1;
   end

   // all runs take under two thousand cycles
   always @(posedge clk) begin
      cycles++;
      if (cycles >= 20000) begin
         $display("timeout, the run did not finish within %0d cycles", cycles);
         $display("%0d beats checked, %0d errors", checks, errors);
         $display("Test failed");
         $finish;
      end
   end

   initial begin
      seed = 37179;
      void'($urandom(seed));
      rst = 1'b1;
      run = 1'b0;
      enabled = 1'b0;
      pingpong = 1'b0;
      in_data = '0;
      dready = 1'b1;
      dlast = 1'b0;
      stall = 1'b0;
      bank = 1'b0;
      checks = 0;
      errors = 0;
      cycles = 0;
      exp_remain = 0;
      for (int i = 0; i < 2**ADDR_W; i++) begin
         image[i] = '0;
      end
      program_store(0, 1, 0, 0, 16, 16, 0);
      program_transfer(0, 0, 16);
      repeat (16) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);
      assert (done === 1'b1 && dvalid === 1'b0) else begin
         errors++;
         $display("error: done_o %h, databus_valid_o %h after reset", done, dvalid);
      end

      // linear store, then send it out
      program_store(0, 1, 0, 4, 16, 16, 3);
      run_and_wait(1'b0, 1'b0, 1'b0);
      program_store(0, 1, 0, 0, 16, 16, 3);
      program_transfer(32'h1000, 63, 16);
      run_and_wait(1'b1, 1'b0, 1'b0);

      // zero the low buffer, strided store with duty
      program_store(0, 1, 0, 1, 64, 64, 0);
      run_and_wait(1'b0, 1'b0, 1'b1);
      program_store(0, 2, 3, 3, 8, 5, 1);
      run_and_wait(1'b0, 1'b0, 1'b0);
      program_store(0, 1, 0, 0, 8, 5, 1);
      program_transfer(32'h2000, 47, 16);
      run_and_wait(1'b1, 1'b0, 1'b0);

      stall <= 1'b1;
      program_transfer(32'h3000, 40, 16);
      run_and_wait(1'b1, 1'b0, 1'b0);

      // each run sends what the previous run stored in the other bank
      // stalls let the stores overtake the reads within a run
      program_store(0, 1, 0, 1, 32, 32, 2);
      program_transfer(32'h4000, 31, 16);
      repeat (3) begin
         run_and_wait(1'b1, 1'b1, 1'b0);
      end
      stall <= 1'b0;

      repeat (4) @(posedge clk);
      $display("%0d beats checked, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

/* source/vwrite_unit.sv */
`timescale 1ns/100ps

module vwrite_unit import vwrite_pkg::*; #(
   parameter int DATA_W   = vwrite_pkg::DATA_W,
   parameter int ADDR_W   = vwrite_pkg::ADDR_W,
   parameter int LEN_W    = vwrite_pkg::LEN_W,
   parameter int PERIOD_W = vwrite_pkg::PERIOD_W
) (
   input  logic                  clk,
   input  logic                  rst,

   input  logic                  run_i,
   input  logic                  enabled_i,
   input  logic                  pingpong_i,
   input  logic [DATA_W-1:0]     in_data_i,
   output logic                  done_o,

   // transfer setup
   input  logic [AXI_ADDR_W-1:0] ext_addr_i,
   input  logic [ADDR_W-1:0]     amount_minus_one_i,
   input  logic [LEN_W-1:0]      length_i,

   // store address generator setup
   input  logic [ADDR_W-1:0]     start_i,
   input  logic [ADDR_W-1:0]     incr_i,
   input  logic [ADDR_W-1:0]     shift_i,
   input  logic [ADDR_W-1:0]     iter_i,
   input  logic [PERIOD_W-1:0]   per_i,
   input  logic [PERIOD_W-1:0]   duty_i,
   input  logic [DELAY_W-1:0]    delay_i,

   output logic                  databus_valid_o,
   input  logic                  databus_ready_i,
   output logic [AXI_ADDR_W-1:0] databus_addr_o,
   output logic [DATA_W-1:0]     databus_wdata_o,
   output logic [DATA_W/8-1:0]   databus_wstrb_o,
   output logic [LEN_W-1:0]      databus_len_o,
   input  logic                  databus_last_i
);

   logic              store_valid;
   logic [ADDR_W-1:0] store_addr;
   logic              store_done;
   buf_addr_u         store_addr_u;

   logic              rd_en;
   logic [ADDR_W-1:0] rd_addr;
   logic [DATA_W-1:0] rd_data;
   buf_addr_u         rd_addr_u;

   logic              word_valid;
   logic              word_ready;
   logic [DATA_W-1:0] word_data;

   logic              xfer_start;
   logic              xfer_done;
   logic [ADDR_W:0]   word_count;

   logic              bank_q;
   logic              done_q;

   assign xfer_start = run_i && enabled_i;
   assign word_count = (ADDR_W+1)'(amount_minus_one_i) + (ADDR_W+1)'(1);

   // store bank flips every run, send bank is the other half
   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         bank_q <= 1'b0;
      end else if (run_i) begin
         bank_q <= pingpong_i ? !bank_q : 1'b0;
      end
   end

   // low from the cycle after run_i until both sides report done
   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         done_q <= 1'b1;
      end else if (run_i) begin
         done_q <= 1'b0;
      end else begin
         done_q <= store_done && xfer_done;
      end
   end

   assign done_o = done_q;

   always_comb begin
      store_addr_u.addr = store_addr;
      if (pingpong_i) begin
         store_addr_u.pp.bank = bank_q;
      end
   end

   always_comb begin
      rd_addr_u.addr = rd_addr;
      if (pingpong_i) begin
         rd_addr_u.pp.bank = !bank_q;
      end
   end

   store_addr_gen #(
      .ADDR_W  (ADDR_W),
      .PERIOD_W(PERIOD_W)
   ) u_store_gen (
      .clk    (clk),
      .rst    (rst),
      .run_i  (run_i),
      .start_i(start_i),
      .incr_i (incr_i),
      .shift_i(shift_i),
      .iter_i (iter_i),
      .per_i  (per_i),
      .duty_i (duty_i),
      .delay_i(delay_i),
      .valid_o(store_valid),
      .addr_o (store_addr),
      .done_o (store_done)
   );

   buffer_ram #(
      .DATA_W(DATA_W),
      .ADDR_W(ADDR_W)
   ) u_buffer (
      .clk      (clk),
      .wr_en_i  (store_valid),
      .wr_addr_i(store_addr_u.addr),
      .wr_data_i(in_data_i),
      .rd_en_i  (rd_en),
      .rd_addr_i(rd_addr_u.addr),
      .rd_data_o(rd_data)
   );

   buffer_reader #(
      .DATA_W(DATA_W),
      .ADDR_W(ADDR_W)
   ) u_reader (
      .clk         (clk),
      .rst         (rst),
      .start_i     (xfer_start),
      .count_i     (word_count),
      .rd_en_o     (rd_en),
      .rd_addr_o   (rd_addr),
      .rd_data_i   (rd_data),
      .word_valid_o(word_valid),
      .word_ready_i(word_ready),
      .word_data_o (word_data)
   );

   burst_writer #(
      .DATA_W(DATA_W),
      .ADDR_W(ADDR_W),
      .LEN_W (LEN_W)
   ) u_writer (
      .clk            (clk),
      .rst            (rst),
      .start_i        (xfer_start),
      .count_i        (word_count),
      .ext_addr_i     (ext_addr_i),
      .length_i       (length_i),
      .word_valid_i   (word_valid),
      .word_ready_o   (word_ready),
      .word_data_i    (word_data),
      .databus_valid_o(databus_valid_o),
      .databus_ready_i(databus_ready_i),
      .databus_addr_o (databus_addr_o),
      .databus_len_o  (databus_len_o),
      .databus_last_i (databus_last_i),
      .databus_wdata_o(databus_wdata_o),
      .done_o         (xfer_done)
   );

   assign databus_wstrb_o = '1;

endmodule

/* databus/burst_writer.sv */
`timescale 1ns/100ps

module burst_writer import vwrite_pkg::*; #(
   parameter int DATA_W = vwrite_pkg::DATA_W,
   parameter int ADDR_W = vwrite_pkg::ADDR_W,
   parameter int LEN_W  = vwrite_pkg::LEN_W
) (
   input  logic                  clk,
   input  logic                  rst,

   input  logic                  start_i,
   input  logic [ADDR_W:0]       count_i,
   input  logic [AXI_ADDR_W-1:0] ext_addr_i,
   input  logic [LEN_W-1:0]      length_i,

   input  logic                  word_valid_i,
   output logic                  word_ready_o,
   input  logic [DATA_W-1:0]     word_data_i,

   output logic                  databus_valid_o,
   input  logic                  databus_ready_i,
   output logic [AXI_ADDR_W-1:0] databus_addr_o,
   output logic [LEN_W-1:0]      databus_len_o,
   input  logic                  databus_last_i,
   output logic [DATA_W-1:0]     databus_wdata_o,

   output logic                  done_o
);

   localparam int CNT_W = ADDR_W + 1;

   logic [CNT_W-1:0]      remain_q;
   logic [AXI_ADDR_W-1:0] addr_q;
   logic                  done_q;

   logic [CNT_W-1:0]      len_ext;
   logic [CNT_W-1:0]      burst_len;
   logic                  beat;
   logic                  burst_end;

   // burst is the programmed length, or what is left if shorter
   assign len_ext   = CNT_W'(length_i);
   assign burst_len = (remain_q > len_ext) ? len_ext : remain_q;

   // words pass straight through while a transfer is open
   assign databus_valid_o = word_valid_i && !done_q;
   assign word_ready_o    = databus_ready_i && !done_q;
   assign databus_wdata_o = word_data_i;

   assign beat      = databus_valid_o && databus_ready_i;
   assign burst_end = beat && databus_last_i;

   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         remain_q <= '0;
         addr_q   <= '0;
         done_q   <= 1'b1;
      end else if (start_i) begin
         remain_q <= count_i;
         addr_q   <= ext_addr_i;
         done_q   <= (count_i == '0);
      end else if (burst_end) begin
         remain_q <= remain_q - burst_len;
         addr_q   <= addr_q + AXI_ADDR_W'(burst_len) * AXI_ADDR_W'(BYTES_PER_WORD);
         // that was the final burst
         if (remain_q == burst_len) begin
            done_q <= 1'b1;
         end
      end
   end

   // address and length only move at a burst boundary
   assign databus_addr_o = addr_q;
   assign databus_len_o  = LEN_W'(burst_len);
   assign done_o         = done_q;

endmodule

/* source/buffer_reader.sv */
`timescale 1ns/100ps

module buffer_reader #(
   parameter int DATA_W = vwrite_pkg::DATA_W,
   parameter int ADDR_W = vwrite_pkg::ADDR_W
) (
   input  logic              clk,
   input  logic              rst,

   input  logic              start_i,
   input  logic [ADDR_W:0]   count_i,

   output logic              rd_en_o,
   output logic [ADDR_W-1:0] rd_addr_o,
   input  logic [DATA_W-1:0] rd_data_i,

   output logic              word_valid_o,
   input  logic              word_ready_i,
   output logic [DATA_W-1:0] word_data_o
);

   logic [ADDR_W:0]   total_q;
   logic [ADDR_W:0]   rd_cnt_q;
   logic              pend_q;

   // two-entry skid queue
   logic [DATA_W-1:0] skid_q [2];
   logic              wr_ptr_q;
   logic              rd_ptr_q;
   logic [1:0]        occ_q;

   logic              push;
   logic              pop;
   logic [2:0]        slots_used;

   assign push = pend_q;
   assign pop  = word_valid_o && word_ready_i;

   // entries held plus the read whose data lands this cycle
   assign slots_used = {1'b0, occ_q} + {2'b00, pend_q};

   assign rd_en_o   = !start_i && (rd_cnt_q < total_q) &&
                      (slots_used < 3'd2 + {2'b00, pop});
   assign rd_addr_o = rd_cnt_q[ADDR_W-1:0];

   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         total_q  <= '0;
         rd_cnt_q <= '0;
         pend_q   <= 1'b0;
         wr_ptr_q <= 1'b0;
         rd_ptr_q <= 1'b0;
         occ_q    <= 2'd0;
      end else if (start_i) begin
         total_q  <= count_i;
         rd_cnt_q <= '0;
         pend_q   <= 1'b0;
         wr_ptr_q <= 1'b0;
         rd_ptr_q <= 1'b0;
         occ_q    <= 2'd0;
      end else begin
         pend_q <= rd_en_o;
         if (rd_en_o) begin
            rd_cnt_q <= rd_cnt_q + 1'b1;
         end
         if (push) begin
            wr_ptr_q <= ~wr_ptr_q;
         end
         if (pop) begin
            rd_ptr_q <= ~rd_ptr_q;
         end
         occ_q <= occ_q + {1'b0, push} - {1'b0, pop};
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         skid_q[wr_ptr_q] <= rd_data_i;
      end
   end

   assign word_valid_o = (occ_q != 2'd0);
   assign word_data_o  = skid_q[rd_ptr_q];

endmodule

/* source/buffer_ram.sv */
`timescale 1ns/100ps

module buffer_ram #(
   parameter int DATA_W = vwrite_pkg::DATA_W,
   parameter int ADDR_W = vwrite_pkg::ADDR_W
) (
   input  logic              clk,

   input  logic              wr_en_i,
   input  logic [ADDR_W-1:0] wr_addr_i,
   input  logic [DATA_W-1:0] wr_data_i,

   input  logic              rd_en_i,
   input  logic [ADDR_W-1:0] rd_addr_i,
   output logic [DATA_W-1:0] rd_data_o
);

   localparam int DEPTH = 2 ** ADDR_W;

   logic [DATA_W-1:0] mem [DEPTH];

   always_ff @(posedge clk) begin
      if (wr_en_i) begin
         mem[wr_addr_i] <= wr_data_i;
      end
   end

   // registered read, data one cycle after rd_en_i
   always_ff @(posedge clk) begin
      if (rd_en_i) begin
         rd_data_o <= mem[rd_addr_i];
      end
   end

endmodule

/* source/store_addr_gen.sv */
`timescale 1ns/100ps

module store_addr_gen import vwrite_pkg::*; #(
   parameter int ADDR_W   = vwrite_pkg::ADDR_W,
   parameter int PERIOD_W = vwrite_pkg::PERIOD_W
) (
   input  logic                clk,
   input  logic                rst,

   input  logic                run_i,

   input  logic [ADDR_W-1:0]   start_i,
   input  logic [ADDR_W-1:0]   incr_i,
   input  logic [ADDR_W-1:0]   shift_i,
   input  logic [ADDR_W-1:0]   iter_i,
   input  logic [PERIOD_W-1:0] per_i,
   input  logic [PERIOD_W-1:0] duty_i,
   input  logic [DELAY_W-1:0]  delay_i,

   output logic                valid_o,
   output logic [ADDR_W-1:0]   addr_o,
   output logic                done_o
);

   logic                active_q;
   logic [DELAY_W-1:0]  delay_q;
   logic [PERIOD_W-1:0] inner_q;
   logic [ADDR_W-1:0]   outer_q;
   logic [ADDR_W-1:0]   addr_q;
   logic                done_q;

   logic                stepping;
   logic                period_end;
   logic                last_period;

   // one step per cycle once the start delay has run out
   assign stepping    = active_q && (delay_q == '0);
   assign period_end  = (inner_q == per_i - PERIOD_W'(1));
   assign last_period = (outer_q == iter_i - ADDR_W'(1));

   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         active_q <= 1'b0;
         delay_q  <= '0;
         inner_q  <= '0;
         outer_q  <= '0;
         addr_q   <= '0;
         done_q   <= 1'b1;
      end else if (run_i) begin
         delay_q <= delay_i;
         inner_q <= '0;
         outer_q <= '0;
         addr_q  <= start_i;
         // nothing to store with an empty loop
         if (iter_i == '0 || per_i == '0) begin
            active_q <= 1'b0;
            done_q   <= 1'b1;
         end else begin
            active_q <= 1'b1;
            done_q   <= 1'b0;
         end
      end else if (active_q) begin
         if (delay_q != '0) begin
            delay_q <= delay_q - DELAY_W'(1);
         end else if (period_end) begin
            inner_q <= '0;
            outer_q <= outer_q + ADDR_W'(1);
            // period boundary adds the shift on top of the step
            addr_q  <= addr_q + incr_i + shift_i;
            if (last_period) begin
               active_q <= 1'b0;
               done_q   <= 1'b1;
            end
         end else begin
            inner_q <= inner_q + PERIOD_W'(1);
            addr_q  <= addr_q + incr_i;
         end
      end
   end

   // only the first duty_i steps of each period store
   assign valid_o = stepping && (inner_q < duty_i);
   assign addr_o  = addr_q;
   assign done_o  = done_q;

endmodule

/* common/vwrite_pkg.sv */
package vwrite_pkg;

   // datapath and databus word width
   localparam int DATA_W = 32;

   // buffer address, 1024 words
   localparam int ADDR_W = 10;

   localparam int AXI_ADDR_W = 32;
   localparam int LEN_W      = 8;
   localparam int PERIOD_W   = 8;
   localparam int DELAY_W    = 8;

   // databus address step for one word
   localparam int BYTES_PER_WORD = DATA_W / 8;

   // bank select and offset when the buffer runs as two halves
   typedef struct packed {
      logic              bank;
      logic [ADDR_W-2:0] offset;
   } buf_bank_addr_t;

   // one buffer address word, read flat or as bank plus offset
   typedef union packed {
      logic [ADDR_W-1:0] addr;
      buf_bank_addr_t    pp;
   } buf_addr_u;

endpackage
